/* hw/cpuTypesPkg.sv */
// shared types for the pipeline; only the listed integer subset decodes, anything else is a bubble
`default_nettype none

package cpuTypesPkg;

  // ==============================
  // sizes and fixed values
  // ==============================
  localparam int WORD_W     = 32;
  localparam int REG_ADDR_W = 5;
  localparam int SHAMT_W    = 5;

  localparam logic [WORD_W-1:0]     RESET_PC = '0;
  localparam logic [REG_ADDR_W-1:0] LINK_REG = 5'd31;

  // major opcodes, R-type is zero
  typedef enum logic [5:0] {
    OP_RTYPE = 6'h00,
    OP_J     = 6'h02,
    OP_JAL   = 6'h03,
    OP_BEQ   = 6'h04,
    OP_BNE   = 6'h05,
    OP_ADDIU = 6'h09,
    OP_ANDI  = 6'h0c,
    OP_ORI   = 6'h0d,
    OP_LUI   = 6'h0f
  } opcodeT;

  // R-type function field
  typedef enum logic [5:0] {
    FN_SLL  = 6'h00,
    FN_SRL  = 6'h02,
    FN_ADDU = 6'h21,
    FN_SUBU = 6'h23,
    FN_AND  = 6'h24,
    FN_OR   = 6'h25,
    FN_XOR  = 6'h26,
    FN_SLT  = 6'h2a
  } functT;

  // sll sits at zero so a cleared register decodes as sll
  typedef enum logic [3:0] {
    ALU_SLL = 4'd0,
    ALU_SRL = 4'd1,
    ALU_ADD = 4'd2,
    ALU_SUB = 4'd3,
    ALU_AND = 4'd4,
    ALU_OR  = 4'd5,
    ALU_XOR = 4'd6,
    ALU_SLT = 4'd7,
    ALU_LUI = 4'd8
  } aluOpT;

  // ==============================
  // stage payloads
  // ==============================
  typedef struct packed {
    logic [WORD_W-1:0] instr;
    logic [WORD_W-1:0] pc;
    logic [WORD_W-1:0] incPC;
  } ifIdT;

  // all zero means no write and no branch
  typedef struct packed {
    logic                  wen;
    logic                  aluSrc;
    logic                  branch;
    logic                  bne;
    logic                  jmp;
    logic                  jl;
    logic                  shiftSel;
    aluOpT                 aluOp;
    logic [REG_ADDR_W-1:0] rs;
    logic [REG_ADDR_W-1:0] rt;
    logic [REG_ADDR_W-1:0] dest;
    logic [WORD_W-1:0]     rdat1;
    logic [WORD_W-1:0]     rdat2;
    logic [WORD_W-1:0]     imm;
    logic [SHAMT_W-1:0]    shamt;
    logic [WORD_W-1:0]     pc;
    logic [WORD_W-1:0]     incPC;
  } idExT;

  typedef struct packed {
    logic                  wen;
    logic [REG_ADDR_W-1:0] dest;
    logic [WORD_W-1:0]     result;
  } exWbT;

endpackage

`default_nettype wire

/* hw/pipeReg.sv */
// stage register for any payload whose all-zero value is a bubble; flush only acts while ihit is high
`timescale 1ns/1ps
`default_nettype none

module pipeReg #(
  parameter type payloadT = logic
) (
  input  logic    CLK,
  input  logic    nRST,
  input  logic    ihit,
  input  logic    enable,
  input  logic    flush,
  input  payloadT d,
  output payloadT q
);

  // ==============================
  // register
  // ==============================
  // priority: reset, flush on a hit, then load
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      q <= '0;
    end
    else if (flush && ihit) begin
      // squash to a bubble
      q <= '0;
    end
    else if (enable) begin
      q <= d;
    end
  end

endmodule

`default_nettype wire

/* hw/fetchUnit.sv */
// program counter only advances on ihit; a redirect is taken on the same hit edge
`timescale 1ns/1ps
`default_nettype none

module fetchUnit import cpuTypesPkg::*; (
  input  logic              CLK,
  input  logic              nRST,
  input  logic              ihit,
  input  logic              redirect,
  input  logic [WORD_W-1:0] target,
  output logic [WORD_W-1:0] pc,
  output logic [WORD_W-1:0] incPC
);

  // sequential next address
  assign incPC = pc + WORD_W'(4);

  // ==============================
  // pc register
  // ==============================
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      pc <= RESET_PC;
    end
    else if (ihit) begin
      // taken branch or jump wins over the step
      if (redirect) begin
        pc <= target;
      end
      else begin
        pc <= incPC;
      end
    end
  end

endmodule

`default_nettype wire

/* hw/regFile.sv */
// 32 x 32 register file, write-through on same-cycle reads, r0 reads zero and is never written
`timescale 1ns/1ps
`default_nettype none

module regFile import cpuTypesPkg::*; (
  input  logic                  CLK,
  input  logic                  nRST,
  input  exWbT                  wr,
  input  logic [REG_ADDR_W-1:0] rsel1,
  input  logic [REG_ADDR_W-1:0] rsel2,
  output logic [WORD_W-1:0]     rdat1,
  output logic [WORD_W-1:0]     rdat2
);

  logic [WORD_W-1:0] regs [2**REG_ADDR_W];

  // read with bypass of the write in flight
  function automatic logic [WORD_W-1:0] readPort(
    input logic [REG_ADDR_W-1:0] sel,
    input exWbT                  w,
    input logic [WORD_W-1:0]     stored
  );
    if (sel == '0) return '0;
    if (w.wen && w.dest == sel) return w.result;
    return stored;
  endfunction

  assign rdat1 = readPort(rsel1, wr, regs[rsel1]);
  assign rdat2 = readPort(rsel2, wr, regs[rsel2]);

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      for (int i = 0; i < 2**REG_ADDR_W; i++) begin
        regs[i] <= '0;
      end
    end
    else if (wr.wen && wr.dest != '0) begin
      regs[wr.dest] <= wr.result;
    end
  end

endmodule

`default_nettype wire

/* hw/instrDecode.sv */
// decode for the supported subset only; unknown opcodes or functs become a bubble in ID/EX
`timescale 1ns/1ps
`default_nettype none

module instrDecode import cpuTypesPkg::*; (
  input  ifIdT ifId,
  input  exWbT wr,
  input  logic CLK,
  input  logic nRST,
  output idExT idEx
);

  opcodeT                op;
  functT                 funct;
  logic [REG_ADDR_W-1:0] rs;
  logic [REG_ADDR_W-1:0] rt;
  logic [REG_ADDR_W-1:0] rd;
  logic [WORD_W-1:0]     rdat1;
  logic [WORD_W-1:0]     rdat2;
  logic [WORD_W-1:0]     signImm;
  logic [WORD_W-1:0]     zeroImm;

  // instruction fields
  assign op      = opcodeT'(ifId.instr[31:26]);
  assign funct   = functT'(ifId.instr[5:0]);
  assign rs      = ifId.instr[25:21];
  assign rt      = ifId.instr[20:16];
  assign rd      = ifId.instr[15:11];
  assign signImm = {{(WORD_W-16){ifId.instr[15]}}, ifId.instr[15:0]};
  assign zeroImm = {{(WORD_W-16){1'b0}}, ifId.instr[15:0]};

  regFile rf (
    .CLK   (CLK),
    .nRST  (nRST),
    .wr    (wr),
    .rsel1 (rs),
    .rsel2 (rt),
    .rdat1 (rdat1),
    .rdat2 (rdat2)
  );

  // ==============================
  // control decode
  // ==============================
  always_comb begin
    idEx       = '0;
    idEx.rs    = rs;
    idEx.rt    = rt;
    idEx.rdat1 = rdat1;
    idEx.rdat2 = rdat2;
    idEx.imm   = signImm;
    idEx.shamt = ifId.instr[10:6];
    idEx.pc    = ifId.pc;
    idEx.incPC = ifId.incPC;

    case (op)
      OP_RTYPE: begin
        idEx.wen  = 1'b1;
        idEx.dest = rd;
        case (funct)
          FN_SLL: begin
            idEx.aluOp    = ALU_SLL;
            idEx.shiftSel = 1'b1;
          end
          FN_SRL: begin
            idEx.aluOp    = ALU_SRL;
            idEx.shiftSel = 1'b1;
          end
          FN_ADDU: idEx.aluOp = ALU_ADD;
          FN_SUBU: idEx.aluOp = ALU_SUB;
          FN_AND:  idEx.aluOp = ALU_AND;
          FN_OR:   idEx.aluOp = ALU_OR;
          FN_XOR:  idEx.aluOp = ALU_XOR;
          FN_SLT:  idEx.aluOp = ALU_SLT;
          default: idEx = '0;
        endcase
      end
      // immediate forms write rt
      OP_ADDIU, OP_ANDI, OP_ORI, OP_LUI: begin
        idEx.wen    = 1'b1;
        idEx.aluSrc = 1'b1;
        idEx.dest   = rt;
        case (op)
          OP_ANDI: begin
            idEx.aluOp = ALU_AND;
            idEx.imm   = zeroImm;
          end
          OP_ORI: begin
            idEx.aluOp = ALU_OR;
            idEx.imm   = zeroImm;
          end
          OP_LUI:  idEx.aluOp = ALU_LUI;
          default: idEx.aluOp = ALU_ADD;
        endcase
      end
      OP_BEQ, OP_BNE: begin
        idEx.branch = 1'b1;
        idEx.bne    = (op == OP_BNE);
      end
      // jump field rides in imm
      OP_J, OP_JAL: begin
        idEx.jmp = 1'b1;
        idEx.imm = {{(WORD_W-26){1'b0}}, ifId.instr[25:0]};
        if (op == OP_JAL) begin
          idEx.jl   = 1'b1;
          idEx.wen  = 1'b1;
          idEx.dest = LINK_REG;
        end
      end
      default: idEx = '0;
    endcase
  end

endmodule

`default_nettype wire

/* hw/aluExecute.sv */
// execute stage; forwards only from EX/WB, older results must come through the register file bypass
`timescale 1ns/1ps
`default_nettype none

module aluExecute import cpuTypesPkg::*; (
  input  idExT              idEx,
  input  exWbT              fwd,
  output exWbT              exWb,
  output logic              redirect,
  output logic [WORD_W-1:0] target
);

  logic [WORD_W-1:0]  rsData;
  logic [WORD_W-1:0]  rtData;
  logic [WORD_W-1:0]  srcB;
  logic [SHAMT_W-1:0] shAmt;
  logic [WORD_W-1:0]  aluOut;
  logic [WORD_W-1:0]  branchTarget;
  logic [WORD_W-1:0]  jumpTarget;
  logic               equal;
  logic               taken;

  // take the EX/WB result when it writes this register
  function automatic logic [WORD_W-1:0] fwdData(
    input logic [REG_ADDR_W-1:0] idx,
    input logic [WORD_W-1:0]     regData,
    input exWbT                  f
  );
    if (f.wen && f.dest != '0 && f.dest == idx) return f.result;
    return regData;
  endfunction

  // ==============================
  // operands
  // ==============================
  assign rsData = fwdData(idEx.rs, idEx.rdat1, fwd);
  assign rtData = fwdData(idEx.rt, idEx.rdat2, fwd);
  assign srcB   = idEx.aluSrc ? idEx.imm : rtData;
  // shamt field or low bits of rs
  assign shAmt  = idEx.shiftSel ? idEx.shamt : rsData[SHAMT_W-1:0];

  // ==============================
  // ALU
  // ==============================
  always_comb begin
    case (idEx.aluOp)
      ALU_SLL: aluOut = srcB << shAmt;
      ALU_SRL: aluOut = srcB >> shAmt;
      ALU_ADD: aluOut = rsData + srcB;
      ALU_SUB: aluOut = rsData - srcB;
      ALU_AND: aluOut = rsData & srcB;
      ALU_OR:  aluOut = rsData | srcB;
      ALU_XOR: aluOut = rsData ^ srcB;
      ALU_SLT: aluOut = {{(WORD_W-1){1'b0}}, $signed(rsData) < $signed(srcB)};
      ALU_LUI: aluOut = {srcB[15:0], 16'h0000};
      default: aluOut = '0;
    endcase
  end

  // jal links the return address instead
  assign exWb.wen    = idEx.wen;
  assign exWb.dest   = idEx.dest;
  assign exWb.result = idEx.jl ? idEx.incPC : aluOut;

  // ==============================
  // branch and jump resolution
  // ==============================
  assign equal        = (rsData == rtData);
  assign taken        = idEx.branch && (equal ^ idEx.bne);
  assign branchTarget = idEx.incPC + {idEx.imm[WORD_W-3:0], 2'b00};
  assign jumpTarget   = {idEx.incPC[WORD_W-1:28], idEx.imm[25:0], 2'b00};

  assign redirect = taken || idEx.jmp;
  assign target   = idEx.jmp ? jumpTarget : branchTarget;

endmodule

`default_nettype wire

/* hw/mipsCore.sv */
// four-stage core without data memory; every register advances only on ihit, instr must match pc
`timescale 1ns/1ps
`default_nettype none

module mipsCore import cpuTypesPkg::*; (
  input  logic                  CLK,
  input  logic                  nRST,
  input  logic                  ihit,
  input  logic [WORD_W-1:0]     instr,
  output logic [WORD_W-1:0]     pc,
  output logic                  wbValid,
  output logic [REG_ADDR_W-1:0] wbDest,
  output logic [WORD_W-1:0]     wbData
);

  ifIdT              ifIdD;
  ifIdT              ifIdQ;
  idExT              idExD;
  idExT              idExQ;
  exWbT              exWbD;
  exWbT              exWbQ;
  logic              redirect;
  logic [WORD_W-1:0] target;
  logic [WORD_W-1:0] incPC;

  // ==============================
  // fetch
  // ==============================
  fetchUnit fetch (
    .CLK(CLK), .nRST(nRST), .ihit(ihit),
    .redirect(redirect), .target(target),
    .pc(pc), .incPC(incPC)
  );

  assign ifIdD = '{instr: instr, pc: pc, incPC: incPC};

  pipeReg #(.payloadT(ifIdT)) ifIdReg (
    .CLK(CLK), .nRST(nRST), .ihit(ihit),
    .enable(ihit), .flush(redirect), .d(ifIdD), .q(ifIdQ)
  );

  // ==============================
  // decode and execute
  // ==============================
  instrDecode decode (
    .ifId(ifIdQ), .wr(exWbQ), .CLK(CLK), .nRST(nRST), .idEx(idExD)
  );

  pipeReg #(.payloadT(idExT)) idExReg (
    .CLK(CLK), .nRST(nRST), .ihit(ihit),
    .enable(ihit), .flush(redirect), .d(idExD), .q(idExQ)
  );

  aluExecute execute (
    .idEx(idExQ), .fwd(exWbQ), .exWb(exWbD),
    .redirect(redirect), .target(target)
  );

  // nothing younger sits behind writeback, so never flushed
  pipeReg #(.payloadT(exWbT)) exWbReg (
    .CLK(CLK), .nRST(nRST), .ihit(ihit),
    .enable(ihit), .flush(1'b0), .d(exWbD), .q(exWbQ)
  );

  // retire report, once per held writeback
  assign wbValid = exWbQ.wen & ihit & (|exWbQ.dest);
  assign wbDest  = exWbQ.dest;
  assign wbData  = exWbQ.result;

endmodule

`default_nettype wire

/* verif/mipsCore_checker.sv */
// bound into mipsCore; checks are idle while nRST is low except the pc value at reset release
`timescale 1ns/1ps
`default_nettype none

module mipsCore_checker import cpuTypesPkg::*; (
  input logic                  CLK,
  input logic                  nRST,
  input logic                  ihit,
  input logic [WORD_W-1:0]     pc,
  input logic                  wbValid,
  input logic [REG_ADDR_W-1:0] wbDest,
  input logic [WORD_W-1:0]     wbData
);

  // r0 writes are never reported
  noZeroDest: assert property (@(posedge CLK) disable iff (!nRST)
    wbValid |-> wbDest != '0)
    else $error("wbValid raised with wbDest zero");

  resetPc: assert property (@(posedge CLK) $rose(nRST) |-> pc == RESET_PC)
    else $error("pc is not the reset address after reset");

  // ==============================
  // low ihit freezes the pipeline
  // ==============================
  holdPc: assert property (@(posedge CLK) disable iff (!nRST)
    !ihit |=> $stable(pc))
    else $error("pc moved on an edge without ihit");

  holdWb: assert property (@(posedge CLK) disable iff (!nRST)
    !ihit |=> $stable(wbDest) && $stable(wbData))
    else $error("writeback register moved on an edge without ihit");

endmodule

bind mipsCore mipsCore_checker chk (
  .CLK(CLK), .nRST(nRST), .ihit(ihit), .pc(pc),
  .wbValid(wbValid), .wbDest(wbDest), .wbData(wbData)
);

`default_nettype wire

/* verif/mipsCore_tb.sv */
// programs branch forward only and end with pc past their last word; instr follows pc every cycle
`timescale 1ns/1ps
`default_nettype none

module mipsCore_tb import cpuTypesPkg::*; ();

  localparam int PERIOD      = 40;
  localparam int NUM_ROWS    = 8;
  localparam int NUM_PROGS   = 4;
  localparam int MAX_WORDS   = 16;
  localparam int WORD_CYCLES = 16;
  localparam int ROW_LIMIT   = MAX_WORDS * 12;
  localparam int TAIL_HITS   = 6;

  logic                  CLK;
  logic                  nRST;
  logic                  ihit;
  logic [WORD_W-1:0]     instr;
  logic [WORD_W-1:0]     pc;
  logic                  wbValid;
  logic [REG_ADDR_W-1:0] wbDest;
  logic [WORD_W-1:0]     wbData;

  logic [31:0] lfsr;
  logic [31:0] progQ [NUM_PROGS][$];
  // dest in the top five bits, data below
  logic [36:0] expQ [NUM_PROGS][$];
  logic [36:0] expEntry;
  int          curProg;
  int          wbIdx;
  int          rowErrs;
  int          checks;
  int          passed;
  int          failed;

  // ==============================
  // test table
  // ==============================
  string rowName [NUM_ROWS] = '{"aluOps", "forwarding", "branches", "jumps",
    "aluOpsGaps", "forwardingGaps", "branchesGaps", "jumpsGaps"};
  int rowProg [NUM_ROWS] = '{0, 1, 2, 3, 0, 1, 2, 3};
  // LFSR bits per cycle, ihit drops when all of them are ones
  int rowGaps [NUM_ROWS] = '{0, 0, 0, 0, 1, 2, 1, 1};

  mipsCore UUT (
    .CLK(CLK), .nRST(nRST), .ihit(ihit), .instr(instr), .pc(pc),
    .wbValid(wbValid), .wbDest(wbDest), .wbData(wbData)
  );

  always #(PERIOD / 2) CLK = ~CLK;

  // instruction assembly, operands in assembler order
  function automatic logic [31:0] rtype(input functT fn, input int rd, input int rs,
                                        input int rt, input int sh);
    return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'(sh), fn};
  endfunction

  function automatic logic [31:0] itype(input opcodeT op, input int rt, input int rs,
                                        input logic [15:0] imm);
    return {op, 5'(rs), 5'(rt), imm};
  endfunction

  function automatic logic [31:0] jtype(input opcodeT op, input int wordIdx);
    return {op, 26'(wordIdx)};
  endfunction

  // Galois form, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsrStep(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // past the program end the core sees nops
  function automatic logic [31:0] fetchWord(input int p, input logic [31:0] addr);
    int idx;
    idx = int'(addr >> 2);
    if (idx < progQ[p].size()) return progQ[p][idx];
    return 32'h0;
  endfunction

  task automatic loadPrograms();
    progQ[0] = '{itype(OP_ORI, 1, 0, 16'h00f0), itype(OP_ADDIU, 2, 0, 16'hfffd),
      itype(OP_LUI, 3, 0, 16'h1234), itype(OP_ANDI, 4, 2, 16'h0ff0),
      rtype(FN_ADDU, 5, 1, 3, 0), rtype(FN_SUBU, 6, 1, 2, 0), rtype(FN_AND, 7, 3, 5, 0),
      rtype(FN_OR, 8, 1, 4, 0), rtype(FN_XOR, 9, 4, 1, 0), rtype(FN_SLT, 10, 2, 1, 0),
      rtype(FN_SLT, 11, 1, 2, 0), rtype(FN_SLL, 12, 0, 1, 4), rtype(FN_SRL, 13, 0, 3, 8),
      rtype(FN_SLL, 0, 0, 1, 2)};
    expQ[0] = '{{5'd1, 32'h0000_00f0}, {5'd2, 32'hffff_fffd}, {5'd3, 32'h1234_0000},
      {5'd4, 32'h0000_0ff0}, {5'd5, 32'h1234_00f0}, {5'd6, 32'h0000_00f3},
      {5'd7, 32'h1234_0000}, {5'd8, 32'h0000_0ff0}, {5'd9, 32'h0000_0f00},
      {5'd10, 32'h0000_0001}, {5'd11, 32'h0000_0000}, {5'd12, 32'h0000_0f00},
      {5'd13, 32'h0012_3400}};
    // dependences at distance one, two, three and four
    progQ[1] = '{itype(OP_ADDIU, 1, 0, 16'd5), rtype(FN_ADDU, 2, 1, 1, 0),
      itype(OP_ADDIU, 3, 0, 16'd7), rtype(FN_SUBU, 4, 2, 1, 0), rtype(FN_ADDU, 5, 3, 2, 0),
      rtype(FN_XOR, 6, 5, 4, 0), rtype(FN_OR, 7, 6, 3, 0)};
    expQ[1] = '{{5'd1, 32'h5}, {5'd2, 32'ha}, {5'd3, 32'h7}, {5'd4, 32'h5},
      {5'd5, 32'h11}, {5'd6, 32'h14}, {5'd7, 32'h17}};
    // words 3, 4, 9 and 10 sit in taken-branch shadows
    progQ[2] = '{itype(OP_ADDIU, 1, 0, 16'd1), itype(OP_ADDIU, 2, 0, 16'd1),
      itype(OP_BEQ, 2, 1, 16'd2), itype(OP_ADDIU, 3, 0, 16'h33), itype(OP_ADDIU, 4, 0, 16'h44),
      itype(OP_ADDIU, 5, 0, 16'h55), itype(OP_BNE, 2, 1, 16'd5), itype(OP_ADDIU, 6, 0, 16'h66),
      itype(OP_BNE, 5, 1, 16'd2), itype(OP_ADDIU, 7, 0, 16'h77), itype(OP_ADDIU, 8, 0, 16'h88),
      itype(OP_ADDIU, 9, 1, 16'h10), itype(OP_BEQ, 5, 1, 16'd3), itype(OP_ADDIU, 10, 0, 16'haa)};
    expQ[2] = '{{5'd1, 32'h1}, {5'd2, 32'h1}, {5'd5, 32'h55}, {5'd6, 32'h66},
      {5'd9, 32'h11}, {5'd10, 32'haa}};
    progQ[3] = '{itype(OP_ADDIU, 1, 0, 16'h11), jtype(OP_J, 4),
      itype(OP_ADDIU, 2, 0, 16'h22), itype(OP_ADDIU, 3, 0, 16'h33), jtype(OP_JAL, 8),
      itype(OP_ADDIU, 4, 0, 16'h44), itype(OP_ADDIU, 5, 0, 16'h55),
      itype(OP_ADDIU, 6, 0, 16'h66), rtype(FN_ADDU, 7, 31, 1, 0),
      itype(OP_ORI, 8, 31, 16'h0100)};
    expQ[3] = '{{5'd1, 32'h11}, {5'd31, 32'h14}, {5'd7, 32'h25}, {5'd8, 32'h114}};
  endtask

  task automatic driveCycle(input int p, input int gaps);
    logic drop;
    drop = (gaps > 0);
    for (int b = 0; b < gaps; b++) begin
      drop = drop & lfsr[0];
      lfsr = lfsrStep(lfsr);
    end
    ihit  = !drop;
    instr = fetchWord(p, pc);
  endtask

  // ==============================
  // writeback compare
  // ==============================
  always @(negedge CLK) begin
    if (nRST && wbValid) begin
      assert (wbIdx < expQ[curProg].size()) else begin
        $display("Unexpected writeback to r%0d at %0t, more than the program retires",
                 wbDest, $time);
        rowErrs++;
      end
      if (wbIdx < expQ[curProg].size()) begin
        expEntry = expQ[curProg][wbIdx];
        checks++;
        assert (wbDest == expEntry[36:32]) else begin
          $display("** Error at %0t: wbDest expected %0d, got %0d",
                   $time, expEntry[36:32], wbDest);
          rowErrs++;
        end
        assert (wbData == expEntry[31:0]) else begin
          $display("** Error at %0t: wbData expected %h, got %h",
                   $time, expEntry[31:0], wbData);
          rowErrs++;
        end
      end
      wbIdx++;
    end
  end

  task automatic runRow(input int r);
    int p;
    int cycles;
    int tail;
    int last;
    p = rowProg[r];
    @(posedge CLK);
    #2;
    nRST    = 1'b0;
    ihit    = 1'b0;
    curProg = p;
    wbIdx   = 0;
    rowErrs = 0;
    repeat (3) @(posedge CLK);
    #2 nRST = 1'b1;
    last   = 4 * progQ[p].size();
    cycles = 0;
    tail   = 0;
    // run until a few hits past the last word have drained the pipeline
    while (tail < TAIL_HITS && cycles < ROW_LIMIT) begin
      @(posedge CLK);
      #2;
      driveCycle(p, rowGaps[r]);
      if (ihit && pc >= last) tail++;
      cycles++;
    end
    @(posedge CLK);
    if (tail < TAIL_HITS) begin
      $display("Test %s timed out, pc did not pass the program end in %0d cycles",
               rowName[r], ROW_LIMIT);
      rowErrs++;
    end
    assert (wbIdx == expQ[p].size()) else begin
      $display("** Error at %0t: writeback count expected %0d, got %0d",
               $time, expQ[p].size(), wbIdx);
      rowErrs++;
    end
    $display("test %0d %s (gap bits %0d): %s, %0d writebacks, %0d errors", r, rowName[r],
             rowGaps[r], (rowErrs == 0) ? "ok" : "failed", wbIdx, rowErrs);
    if (rowErrs == 0) passed++;
    else failed++;
  endtask

  // ==============================
  // main sequence and watchdog
  // ==============================
  initial begin
    CLK    = 1'b0;
    nRST   = 1'b0;
    ihit   = 1'b0;
    instr  = '0;
    lfsr   = 32'h860a_4915;
    checks = 0;
    passed = 0;
    failed = 0;
    loadPrograms();
    for (int r = 0; r < NUM_ROWS; r++) begin
      runRow(r);
    end
    $display("tests %0d, passed %0d, failed %0d, writebacks checked %0d",
             NUM_ROWS, passed, failed, checks);
    if (failed == 0) begin
      $display("=== PASS ===");
    end
    else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  initial begin
    #(NUM_ROWS * MAX_WORDS * WORD_CYCLES * PERIOD);
    $display("Watchdog expired at %0t, the test table did not finish", $time);
    $display("=== FAIL ===");
    $finish;
  end

endmodule

`default_nettype wire

/* mipsCore.f */
hw/cpuTypesPkg.sv
hw/pipeReg.sv
hw/fetchUnit.sv
hw/regFile.sv
hw/instrDecode.sv
hw/aluExecute.sv
hw/mipsCore.sv
verif/mipsCore_checker.sv
verif/mipsCore_tb.sv

/* Makefile */
TOP = mipsCore_tb
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and $(LOG)"

test:
	rm -f $(LOG)
	verilator --binary --timing --assert -Wno-fatal -f mipsCore.f \
		--top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^=== PASS ===$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
